// File: build.f
rtl/pokey_pkg.sv
rtl/clock_divider.sv
rtl/pot_scanner.sv
rtl/pot_registers.sv
rtl/trigger_latch.sv
rtl/pokey_ctrl_top.sv
tests/tb_pokey_ctrl.sv

// File: rtl/clock_divider.sv
`timescale 1ns/1ns

module clock_divider #(
    parameter int CLK_DIV = 1800
) (
    input  logic clk_27mhz_fpga,
    input  logic rst_n,
    input  logic restart,   // realigns tick phase to potgo
    input  logic enable,    // counts only while a scan runs
    output logic tick
);

    // at least one bit even for tiny divides
    localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
    localparam logic [CW-1:0] CNT_LAST = CW'(CLK_DIV - 1);

    logic [CW-1:0] cnt;

    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (restart || (enable && cnt == CNT_LAST)) begin
            cnt <= '0;          // wrap or realign
        end else if (enable) begin
            cnt <= cnt + 1'b1;
        end
    end

    // stale count from a previous scan is masked by restart
    assign tick = enable && !restart && (cnt == CNT_LAST);

endmodule

// File: rtl/pokey_ctrl_top.sv
`timescale 1ns/1ns

module pokey_ctrl_top #(
    parameter int CLK_DIV = 1800,   // 27 MHz / 1800 = 15 kHz scan line rate
    parameter int POT_MAX = 228
) (
    input  logic                  clk_27mhz_fpga,
    input  logic                  rst_n,
    input  logic                  potgo,
    input  logic [1:0]            pot_in,
    input  pokey_pkg::trig_t      trig_in,
    input  pokey_pkg::gractl_t    gractl,
    output logic                  pot_release,
    output pokey_pkg::pot_value_t pot0,
    output pokey_pkg::pot_value_t pot1,
    output pokey_pkg::allpot_t    allpot,
    output pokey_pkg::trig_t      trig
);

    pokey_pkg::pot_capture_t capture;   // scanner -> registers
    logic                    scan_start;

    // producer: counts ticks, emits captures
    pot_scanner #(
        .CLK_DIV (CLK_DIV),
        .POT_MAX (POT_MAX)
    ) u_pot_scanner (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst_n          (rst_n),
        .potgo          (potgo),
        .pot_in         (pot_in),
        .pot_release    (pot_release),
        .capture        (capture),
        .scan_start     (scan_start),
        .scan_active    ()              // only the divider needs it
    );

    // buffer: host-visible pot values and allpot
    pot_registers u_pot_registers (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst_n          (rst_n),
        .capture        (capture),
        .scan_start     (scan_start),
        .pot0           (pot0),
        .pot1           (pot1),
        .allpot         (allpot)
    );

    // buttons run beside the pot path
    trigger_latch u_trigger_latch (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst_n          (rst_n),
        .trig_in        (trig_in),
        .gractl         (gractl),
        .trig           (trig)
    );

endmodule

// File: rtl/pokey_pkg.sv
package pokey_pkg;

    // pot register value, tick count at capture
    typedef logic [7:0] pot_value_t;

    // one bit per pot, high while that pot is still scanning
    typedef logic [1:0] allpot_t;

    // trigger buttons, active low
    typedef logic [3:0] trig_t;

    // graphics control register as seen by the host
    typedef logic [7:0] gractl_t;

    // gractl bit that holds the triggers latched
    localparam int unsigned GRACTL_LATCH_BIT = 2;

    // one capture strobe from the scanner to the pot registers
    typedef struct packed {
        logic       valid;  // single-cycle strobe
        logic       index;  // 0 = pot0, 1 = pot1
        pot_value_t value;  // count latched for that pot
    } pot_capture_t;

    // pot scan sequencer
    typedef enum logic [0:0] {
        SCAN_IDLE = 1'b0,   // dump line held, counter frozen
        SCAN_RUN  = 1'b1    // caps charging, counting ticks
    } scan_state_t;

endpackage

// File: rtl/pot_registers.sv
`timescale 1ns/1ns

module pot_registers (
    input  logic                    clk_27mhz_fpga,
    input  logic                    rst_n,
    input  pokey_pkg::pot_capture_t capture,
    input  logic                    scan_start,
    output pokey_pkg::pot_value_t   pot0,
    output pokey_pkg::pot_value_t   pot1,
    output pokey_pkg::allpot_t      allpot
);

    // strobe decode per pot
    logic wr_pot0;
    logic wr_pot1;

    assign wr_pot0 = capture.valid && !capture.index;
    assign wr_pot1 = capture.valid &&  capture.index;

    // values persist across scans, host reads last result mid-scan
    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            pot0 <= '0;
            pot1 <= '0;
        end else begin
            if (wr_pot0) begin
                pot0 <= capture.value;
            end
            if (wr_pot1) begin
                pot1 <= capture.value;
            end
        end
    end

    // allpot: ones at start, each bit drops as its pot lands
    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            allpot <= '0;
        end else begin
            if (scan_start) begin
                allpot <= '1;
            end
            // same edge as the register write
            if (wr_pot0) begin
                allpot[0] <= 1'b0;
            end
            if (wr_pot1) begin
                allpot[1] <= 1'b0;
            end
        end
    end

endmodule

// File: rtl/pot_scanner.sv
`timescale 1ns/1ns

module pot_scanner #(
    parameter int CLK_DIV = 1800,
    parameter int POT_MAX = 228
) (
    input  logic                    clk_27mhz_fpga,
    input  logic                    rst_n,
    input  logic                    potgo,        // one-cycle start strobe
    input  logic [1:0]              pot_in,       // comparator outputs, async
    output logic                    pot_release,  // high = dump caps
    output pokey_pkg::pot_capture_t capture,
    output logic                    scan_start,
    output logic                    scan_active
);

    localparam pokey_pkg::pot_value_t POT_FULL = pokey_pkg::pot_value_t'(POT_MAX);
    localparam pokey_pkg::pot_value_t POT_LAST = pokey_pkg::pot_value_t'(POT_MAX - 1);

    pokey_pkg::scan_state_t state;
    pokey_pkg::pot_value_t  count;      // ticks since scan start
    pokey_pkg::pot_value_t  pend_val;   // pot1 value waiting its turn
    pokey_pkg::pot_value_t  hit_val [2];
    logic [1:0]             pot_meta;
    logic [1:0]             pot_sync;
    logic [1:0]             captured;   // pot already landed this scan
    logic [1:0]             hit;
    logic                   pend;       // pot1 capture deferred one cycle
    logic                   restart;
    logic                   tick;
    logic                   at_end;

    clock_divider #(
        .CLK_DIV (CLK_DIV)
    ) u_clock_divider (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst_n          (rst_n),
        .restart        (restart),
        .enable         (scan_active),
        .tick           (tick)
    );

    assign scan_active = (state == pokey_pkg::SCAN_RUN);
    assign pot_release = !scan_active;      // caps dump whenever idle
    assign at_end      = (count == POT_LAST); // this tick finishes the scan

    // which pots land on this tick, and with what count
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]     = !captured[i] && (pot_sync[i] || at_end);
            hit_val[i] = pot_sync[i] ? count : POT_FULL;    // never crossed -> max
        end
    end

    // two-flop synchronizer on the comparators
    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            pot_meta <= '0;
            pot_sync <= '0;
        end else begin
            pot_meta <= pot_in;
            pot_sync <= pot_meta;
        end
    end

    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            state         <= pokey_pkg::SCAN_IDLE;
            count         <= '0;
            captured      <= '0;
            pend          <= 1'b0;
            scan_start    <= 1'b0;
            restart       <= 1'b0;
            capture.valid <= 1'b0;
        end else begin
            scan_start    <= 1'b0;
            restart       <= 1'b0;
            capture.valid <= 1'b0;
            if (potgo) begin
                // also restarts a scan in progress
                state      <= pokey_pkg::SCAN_RUN;
                scan_start <= 1'b1;
                restart    <= 1'b1;
                count      <= '0;
                captured   <= '0;
                pend       <= 1'b0;
            end else begin
                if (pend) begin
                    capture <= '{valid: 1'b1, index: 1'b1, value: pend_val};
                    pend    <= 1'b0;
                end
                if (scan_active && tick) begin
                    count    <= count + 1'b1;
                    captured <= captured | hit;
                    if (hit[0]) begin
                        capture <= '{valid: 1'b1, index: 1'b0, value: hit_val[0]};
                    end else if (hit[1]) begin
                        capture <= '{valid: 1'b1, index: 1'b1, value: hit_val[1]};
                    end
                    if (hit[0] && hit[1]) begin
                        pend     <= 1'b1;   // pot1 goes next cycle
                        pend_val <= hit_val[1];
                    end
                    if (at_end) begin
                        state <= pokey_pkg::SCAN_IDLE;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/trigger_latch.sv
`timescale 1ns/1ns

module trigger_latch (
    input  logic               clk_27mhz_fpga,
    input  logic               rst_n,
    input  pokey_pkg::trig_t   trig_in,     // raw buttons, 0 = pressed
    input  pokey_pkg::gractl_t gractl,
    output pokey_pkg::trig_t   trig
);

    pokey_pkg::trig_t trig_meta;
    pokey_pkg::trig_t trig_sync;
    pokey_pkg::trig_t held;         // sticky lows while latched
    logic             latch_en;

    assign latch_en = gractl[pokey_pkg::GRACTL_LATCH_BIT];

    // buttons are asynchronous to the board clock
    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            trig_meta <= '1;
            trig_sync <= '1;
        end else begin
            trig_meta <= trig_in;
            trig_sync <= trig_meta;
        end
    end

    always_ff @(posedge clk_27mhz_fpga) begin
        if (!rst_n) begin
            held <= '1;
            trig <= '1;     // nothing pressed
        end else begin
            if (latch_en) begin
                held <= held & trig_sync;   // a press sticks
            end else begin
                held <= '1;                 // latch off frees everything
            end
            // output register, third stage of latency
            if (latch_en) begin
                trig <= held & trig_sync;
            end else begin
                trig <= trig_sync;
            end
        end
    end

endmodule

// File: tests/pokey_ctrl_trace.txt
# P name v0 v1 exp0 exp1 : decimal, v is the tick count when the pot rises, 255 = never
# T name gractl trig_in trig_expected : hex, gractl bit 2 latches the triggers
P p_zero       0   0   0   0
P p_one        1   5   1   5
P p_mid       64 100  64 100
P p_rev      150   3 150   3
P p_wide      17 200  17 200
P p_top      227 227 227 227
P p_none0    255  40 228  40
P p_none1     90 255  90 228
P p_none     255 255 228 228
P p_near       2 226   2 226
# gractl only changes in steps where trig_in is unchanged
T t_idle       00 f f
T t_press0     00 e e
T t_release0   00 f f
T t_multi      00 5 5
T t_allup      00 f f
T t_latch_on   04 f f
T t_lpress1    04 d d
T t_lhold1     04 f d
T t_lpress3    04 7 5
T t_lhold      04 f 5
T t_free_fb    fb f f
T t_latch_0c   0c f f
T t_lpress0    0c e e
T t_lhold0     0c f e
T t_unlatch    00 f f

// File: tests/tb_pokey_ctrl.sv
`timescale 1ns/1ns

module tb_pokey_ctrl;

    localparam int CLK_DIV = 8;
    localparam int POT_MAX = 228;
    localparam int NEVER   = 255;   // trace marker, pot stays low

    typedef logic [8*24-1:0] name_t;

    // one trace line, scan case or trigger step
    typedef struct packed {
        logic                  is_scan;
        name_t                 name;
        logic [7:0]            v0;
        logic [7:0]            v1;
        pokey_pkg::pot_value_t exp0;
        pokey_pkg::pot_value_t exp1;
        pokey_pkg::gractl_t    gractl;
        pokey_pkg::trig_t      trig_in;
        pokey_pkg::trig_t      trig_exp;
    } step_t;

    logic                  clk_27mhz_fpga;
    logic                  rst_n;
    logic                  potgo;
    logic [1:0]            pot_in;
    pokey_pkg::trig_t      trig_in;
    pokey_pkg::gractl_t    gractl;
    logic                  pot_release;
    pokey_pkg::pot_value_t pot0;
    pokey_pkg::pot_value_t pot1;
    pokey_pkg::allpot_t    allpot;
    pokey_pkg::trig_t      trig;

    step_t                 steps[$];
    pokey_pkg::pot_value_t prev0;       // register contents from the last scan
    pokey_pkg::pot_value_t prev1;
    pokey_pkg::trig_t      last_trig_exp;   // trig value settled by the previous step
    logic [7:0]            lfsr;
    int                    value_errs;
    int                    other_errs;
    int                    checks;
    int                    n_scan;
    int                    n_trig;
    int                    wd_cycles;
    logic                  wd_armed;

    pokey_ctrl_top #(
        .CLK_DIV (CLK_DIV),
        .POT_MAX (POT_MAX)
    ) u_pokey_ctrl_top (
        .clk_27mhz_fpga (clk_27mhz_fpga),
        .rst_n          (rst_n),
        .potgo          (potgo),
        .pot_in         (pot_in),
        .trig_in        (trig_in),
        .gractl         (gractl),
        .pot_release    (pot_release),
        .pot0           (pot0),
        .pot1           (pot1),
        .allpot         (allpot),
        .trig           (trig)
    );

    initial begin
        clk_27mhz_fpga = 1'b0;
        forever #20 clk_27mhz_fpga = ~clk_27mhz_fpga;  // 40 ns period
    end

    // galois, taps 0xb8, one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 8'hb8;
        end
        return b;
    endfunction

    task automatic check_pot(input name_t name, input string what,
                             input pokey_pkg::pot_value_t exp, input pokey_pkg::pot_value_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0s %0s: expected %0d actual %0d", name, what, exp, act);
        end
    endtask

    task automatic check_allpot(input name_t name, input string what,
                                input pokey_pkg::allpot_t exp, input pokey_pkg::allpot_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0s %0s: expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic check_trig(input name_t name, input string what,
                              input pokey_pkg::trig_t exp, input pokey_pkg::trig_t act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0s %0s: expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic check_release(input name_t name, input string what,
                                 input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            value_errs++;
            $display("[ERROR] %0s %0s: expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic read_trace();
        int               fd;
        int               code;
        int               a, b, c, d;
        logic [7:0]       kind;
        logic [8*120-1:0] line;
        name_t            nm;
        step_t            s;
        fd = $fopen("tests/pokey_ctrl_trace.txt", "r");
        if (fd == 0) begin
            other_errs++;
            $display("could not open the trace file tests/pokey_ctrl_trace.txt");
            return;
        end
        while ($fscanf(fd, " %s", kind) == 1) begin
            s = '0;
            if (kind == "#") begin
                code = $fgets(line, fd);    // column notes
            end else if (kind == "P") begin
                code = $fscanf(fd, " %s %d %d %d %d", nm, a, b, c, d);
                if (code == 5) begin
                    s = '{1'b1, nm, a[7:0], b[7:0], c[7:0], d[7:0], 8'h00, 4'hf, 4'hf};
                    steps.push_back(s);
                    n_scan++;
                end else begin
                    other_errs++;
                    $display("scan line %0s in the trace file has missing fields", nm);
                end
            end else begin
                code = $fscanf(fd, " %s %h %h %h", nm, a, b, c);
                if (code == 4) begin
                    s = '{1'b0, nm, 8'd0, 8'd0, 8'd0, 8'd0, a[7:0], b[3:0], c[3:0]};
                    steps.push_back(s);
                    n_trig++;
                end else begin
                    other_errs++;
                    $display("trigger line %0s in the trace file has missing fields", nm);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic scan_case(input step_t s);
        int                     c;
        int                     gap;
        logic                   done;
        pokey_pkg::scan_state_t st;
        gap = 3;
        for (int i = 0; i < 3; i++) begin
            gap += int'(lfsr_bit()) << i;   // extra idle 0..7
        end
        repeat (gap) @(posedge clk_27mhz_fpga);
        potgo <= 1'b1;
        @(posedge clk_27mhz_fpga);          // edge E, potgo seen here
        potgo <= 1'b0;
        c    = 0;
        done = 1'b0;
        while (!done && c < (POT_MAX + 4) * CLK_DIV) begin
            @(posedge clk_27mhz_fpga);
            c++;
            if (s.v0 != NEVER && c == 2 + s.v0 * CLK_DIV) pot_in[0] <= 1'b1;
            if (s.v1 != NEVER && c == 2 + s.v1 * CLK_DIV) pot_in[1] <= 1'b1;
            @(negedge clk_27mhz_fpga);
            if (c == 3) begin   // well before the first possible capture
                check_release(s.name, "pot_release mid-scan", 1'b0, pot_release);
                check_allpot(s.name, "allpot mid-scan", 2'b11, allpot);
                check_pot(s.name, "pot0 held", prev0, pot0);
                check_pot(s.name, "pot1 held", prev1, pot1);
            end
            done = (c > 3) && pot_release && (allpot == '0);
        end
        if (!done) begin
            other_errs++;
            $display("scan %0s never finished, allpot did not clear", s.name);
        end
        check_pot(s.name, "pot0", s.exp0, pot0);
        check_pot(s.name, "pot1", s.exp1, pot1);
        prev0 = s.exp0;
        prev1 = s.exp1;
        st = pot_release ? pokey_pkg::SCAN_IDLE : pokey_pkg::SCAN_RUN;
        $display("%0s: pot0 %0d pot1 %0d, scanner %s", s.name, pot0, pot1, st.name());
        @(posedge clk_27mhz_fpga);
        pot_in <= 2'b00;                    // caps dumped again
    endtask

    task automatic trigger_step(input step_t s);
        logic moved;
        // button edge with gractl steady, old value must survive two edges
        moved = (s.trig_in !== trig_in) && (s.gractl === gractl);
        @(posedge clk_27mhz_fpga);
        gractl  <= s.gractl;
        trig_in <= s.trig_in;
        repeat (2) @(posedge clk_27mhz_fpga);   // two sync stages
        @(negedge clk_27mhz_fpga);
        if (moved) begin
            check_trig(s.name, "trig before latency", last_trig_exp, trig);
        end
        @(posedge clk_27mhz_fpga);              // output reg
        @(negedge clk_27mhz_fpga);
        check_trig(s.name, "trig", s.trig_exp, trig);
        last_trig_exp = s.trig_exp;
    endtask

    task automatic report_counts();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
    endtask

    initial begin
        wait (wd_armed === 1'b1);
        repeat (wd_cycles) @(posedge clk_27mhz_fpga);
        $display("watchdog expired after %0d cycles, run stopped", wd_cycles);
        report_counts();
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        potgo         = 1'b0;
        pot_in        = 2'b00;
        trig_in       = '1;
        gractl        = '0;
        lfsr          = 8'd20;
        prev0         = '0;
        prev1         = '0;
        last_trig_exp = 4'hf;
        value_errs    = 0;
        other_errs    = 0;
        checks        = 0;
        n_scan        = 0;
        n_trig        = 0;
        wd_armed      = 1'b0;
        read_trace();
        wd_cycles = n_scan * (POT_MAX + 4) * CLK_DIV + n_trig * 10 + 200;
        wd_armed  = 1'b1;
        repeat (4) @(posedge clk_27mhz_fpga);
        rst_n <= 1'b1;
        @(negedge clk_27mhz_fpga);
        check_release("reset", "pot_release", 1'b1, pot_release);
        check_pot("reset", "pot0", 8'd0, pot0);
        check_pot("reset", "pot1", 8'd0, pot1);
        check_allpot("reset", "allpot", 2'b00, allpot);
        check_trig("reset", "trig", 4'hf, trig);
        foreach (steps[i]) begin
            if (steps[i].is_scan) begin
                scan_case(steps[i]);
            end else begin
                trigger_step(steps[i]);
            end
        end
        report_counts();
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
